// File: flist.f
+incdir+include
source/engine_io_pkg.sv
source/tick_if.sv
source/timebase.sv
source/reg_map.sv
source/countdown_timer.sv
source/power_relay.sv
source/ignition_capture.sv
source/injector_timer.sv
source/event_controller.sv
source/engine_io_top.sv
tests/tb_engine_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the engine I/O testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_engine_io \
    -f flist.f -o tb_engine_io_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_engine_io_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: include/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// one-cycle write strobe, driven on the falling edge.
task automatic bus_write(input reg_addr_e a, input word_t d);
    @(negedge sysclk);
    wr_en   = 1'b1;
    addr    = a;
    wr_data = d;
    @(negedge sysclk);
    wr_en   = 1'b0;
endtask

// one-cycle read strobe, data is registered and stable by the next falling edge.
task automatic bus_read(input reg_addr_e a, output word_t d);
    @(negedge sysclk);
    rd_en = 1'b1;
    addr  = a;
    @(negedge sysclk);
    rd_en = 1'b0;
    d     = rd_data;
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(negedge sysclk);
endtask

// coil input is active low, two cycles low make one edge.
task automatic coil_pulse();
    @(negedge sysclk);
    ign_coil_lo = 1'b0;
    idle_cycles(2);
    ign_coil_lo = 1'b1;
endtask

// polls irq once per cycle until it is high or the limit runs out.
task automatic wait_irq(input int limit, output int cycles);
    cycles = 0;
    while (!irq && cycles < limit) begin
        @(negedge sysclk);
        cycles++;
    end
    if (!irq) begin
        errors++;
        $display("timeout: irq did not rise within %0d cycles", limit);
    end
endtask

// waits for injector_open to reach the given level.
task automatic wait_injector(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (injector_open != level && cycles < limit) begin
        @(negedge sysclk);
        cycles++;
    end
    if (injector_open != level) begin
        errors++;
        $display("timeout: injector_open did not go to %0b within %0d cycles", level, limit);
    end
endtask

`endif

// File: tests/tb_engine_io.sv
`timescale 1ns/1ps

module tb_engine_io import engine_io_pkg::*; ();

    // one microsecond is five clock cycles of 4 ns.
    localparam int CYC_US   = 5;
    localparam int CYC_TICK = 100;
    localparam int CYC_MS   = 5000;

    logic      sysclk;
    logic      rst_n;
    logic      wr_en;
    logic      rd_en;
    reg_addr_e addr;
    word_t     wr_data;
    logic      halt;
    logic      power_lost;
    logic      ignition_switch_off;
    logic      ign_coil_lo;
    word_t     rd_data;
    logic      power_relay_pwm;
    logic      injector_open;
    logic      irq;
    logic [1:0] scope;

    integer seed;
    int     errors;
    int     tests;
    int     passed;
    int     mark;
    int     n;
    int     cyc;
    int     hi_cnt;
    word_t  v;
    word_t  prev;
    word_t  cap;
    logic   quiet_window;
    logic   no_puff_window;

    engine_io_top #(.CLK_PER_US(CYC_US)) uut (
        .sysclk(sysclk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en), .addr(addr),
        .wr_data(wr_data), .halt(halt), .power_lost(power_lost),
        .ignition_switch_off(ignition_switch_off), .ign_coil_lo(ign_coil_lo),
        .rd_data(rd_data), .power_relay_pwm(power_relay_pwm),
        .injector_open(injector_open), .irq(irq), .scope(scope)
    );

    always #2 sysclk = ~sysclk;

    `include "tb_bus_tasks.svh"

    // outputs stay low right after reset.
    assert property (@(posedge sysclk) disable iff (!rst_n)
        !(quiet_window && (power_relay_pwm || injector_open || irq)))
        else begin
            errors++;
            $display("** Error at %0t: output high while idle after reset", $time);
        end

    // a zero puff length never opens the injector.
    assert property (@(posedge sysclk) disable iff (!rst_n) !(no_puff_window && injector_open))
        else begin
            errors++;
            $display("** Error at %0t: injector opened with zero length", $time);
        end

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input string what, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == mark) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
        end
        mark = errors;
    endtask

    initial begin
        sysclk = 1'b0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr = REG_USTIMER0;
        wr_data = '0;
        halt = 1'b0;
        power_lost = 1'b0;
        ignition_switch_off = 1'b0;
        ign_coil_lo = 1'b1;
        seed = 40;
        errors = 0;
        tests = 0;
        passed = 0;
        mark = 0;
        quiet_window = 1'b0;
        no_puff_window = 1'b0;
        idle_cycles(8);
        rst_n = 1'b1;

        // reset values.
        quiet_window = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_read(reg_addr_e'(i), v);
            check_value("register after reset", v, '0);
        end
        quiet_window = 1'b0;
        end_test("reset");

        // microsecond timer, readbacks must never increase.
        n = 1 + ({$random(seed)} % 200);
        prev = word_t'(n);
        cyc = 0;
        bus_write(REG_USTIMER0, word_t'(n));
        while (!irq && cyc < CYC_US * (n + 10)) begin
            bus_read(REG_USTIMER0, v);
            cyc += 2;
            check_range("ustimer0 readback", int'(v), 0, int'(prev));
            prev = v;
        end
        if (!irq) begin
            errors++;
            $display("timeout: ustimer0 never raised irq");
        end
        check_range("ustimer0 cycles", cyc, CYC_US * (n - 1), CYC_US * (n + 1));
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_USTIMER0));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_USTIMER0));
        check_value("irq after ack", word_t'(irq), '0);
        n = 1 + ({$random(seed)} % 3);
        bus_write(REG_MSTIMER0, word_t'(n));
        wait_irq(CYC_MS * (n + 2), cyc);
        check_range("mstimer0 cycles", cyc, CYC_MS * (n - 1), CYC_MS * (n + 1));
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_MSTIMER0));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_MSTIMER0));
        check_value("irq after ack", word_t'(irq), '0);
        end_test("countdown timers");

        // PWM high time over one 250-cycle period, then again under halt.
        n = 1 + ({$random(seed)} % 49);
        bus_write(REG_POWER_DUTY, word_t'(n));
        bus_write(REG_USTIMER0, 16'd1000);
        idle_cycles(300);
        for (int pass = 0; pass < 2; pass++) begin
            halt = (pass == 1);
            bus_read(REG_USTIMER0, prev);
            hi_cnt = 0;
            repeat (50 * CYC_US) begin
                @(negedge sysclk);
                if (power_relay_pwm) hi_cnt++;
            end
            check_range("pwm high cycles", hi_cnt, CYC_US * n, CYC_US * n);
            bus_read(REG_USTIMER0, v);
            if (halt) check_value("ustimer0 under halt", v, prev);
        end
        halt = 1'b0;
        bus_write(REG_POWER_DUTY, '0);
        bus_write(REG_USTIMER0, '0);
        end_test("pwm and halt");

        // ignition period capture, blanking and timeout.
        idle_cycles(90 * CYC_TICK);
        coil_pulse();
        idle_cycles(5);
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_IGN_CAPTURE));
        n = 81 + ({$random(seed)} % 40);
        idle_cycles(n * CYC_TICK - 7);
        coil_pulse();
        idle_cycles(5);
        bus_read(REG_IGN_CAPTURE, cap);
        check_range("captured period", int'(cap), n - 1, n + 1);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_IGN_CAPTURE));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_IGN_CAPTURE));
        idle_cycles(40 * CYC_TICK - 9);
        coil_pulse();
        idle_cycles(5);
        bus_read(REG_IGN_CAPTURE, v);
        check_value("capture after blanked edge", v, cap);
        check_value("irq after blanked edge", word_t'(irq), '0);
        wait_irq(33000 * CYC_TICK, cyc);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_IGN_TIMEOUT));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_IGN_TIMEOUT));
        end_test("ignition capture");

        // injector puff length after a captured edge.
        n = 5 + ({$random(seed)} % 56);
        bus_write(REG_EFI_LEN_US, word_t'(n));
        idle_cycles(90 * CYC_TICK);
        coil_pulse();
        wait_injector(1'b1, 10, cyc);
        wait_injector(1'b0, CYC_US * (n + 10), cyc);
        check_range("injector open cycles", cyc, CYC_US * (n - 1), CYC_US * (n + 1));
        idle_cycles(3);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_IGN_CAPTURE));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_IGN_CAPTURE));
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_PUFF_END));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_PUFF_END));
        // zero length, the edge is captured but no puff follows.
        no_puff_window = 1'b1;
        bus_write(REG_EFI_LEN_US, '0);
        idle_cycles(90 * CYC_TICK);
        coil_pulse();
        idle_cycles(20 * CYC_US);
        no_puff_window = 1'b0;
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_IGN_CAPTURE));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_IGN_CAPTURE));
        check_value("irq after zero puff", word_t'(irq), '0);
        end_test("injector");

        // event priority, power loss beats soft events, soft reset clears all.
        // bit 14 rides along to the scope pins.
        bus_write(REG_SOFT_EVENT, 16'h4009);
        idle_cycles(2);
        check_value("scope", word_t'(scope), 16'h0002);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_SOFT0));
        bus_write(REG_EVENT_PRIORITY, word_t'(EV_SOFT0));
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_SOFT3));
        power_lost = 1'b1;
        idle_cycles(5);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority", v, word_t'(EV_POWER_LOST));
        bus_write(REG_SOFT_EVENT, 16'h8000);
        idle_cycles(2);
        check_value("irq in soft reset", word_t'(irq), '0);
        check_value("scope in soft reset", word_t'(scope), '0);
        bus_write(REG_SOFT_EVENT, '0);
        idle_cycles(2);
        bus_read(REG_EVENT_PRIORITY, v);
        check_value("priority after soft reset", v, word_t'(EV_NONE));
        check_value("irq after soft reset", word_t'(irq), '0);
        power_lost = 1'b0;
        end_test("event priority");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: source/engine_io_top.sv
`timescale 1ns/1ps

module engine_io_top import engine_io_pkg::*; #(
    parameter int CLK_PER_US    = 50,
    parameter int US_PER_TICK   = 20,
    parameter int TICKS_PER_MS  = 50,
    parameter int PWM_PERIOD_US = 50,
    parameter int BLANK_TICKS   = 80
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic       rd_en,
    input  reg_addr_e  addr,
    input  word_t      wr_data,
    input  logic       halt,
    input  logic       power_lost,
    input  logic       ignition_switch_off,
    input  logic       ign_coil_lo,
    output word_t      rd_data,
    output logic       power_relay_pwm,
    output logic       injector_open,
    output logic       irq,
    output logic [1:0] scope
);

    logic [NUM_REGS-1:0]   load;
    word_t                 load_data;
    word_t                 ustimer0_val, mstimer0_val, mstimer1_val;
    logic                  ustimer0_expired, mstimer0_expired, mstimer1_expired;
    word_t                 power_status, ign_capture_val, priority_val;
    word_t                 efi_len_us, ign_timeout_len, soft_event;
    logic                  power_lost_sync, ign_switch_off_sync;
    logic                  capture, timeout, puff;
    logic [NUM_EVENTS-1:0] event_vec;

    tick_if ticks ();

    timebase #(
        .CLK_PER_US(CLK_PER_US), .US_PER_TICK(US_PER_TICK), .TICKS_PER_MS(TICKS_PER_MS)
    ) u_timebase (.sysclk(sysclk), .rst_n(rst_n), .halt(halt), .ticks(ticks));

    reg_map u_reg_map (
        .sysclk(sysclk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en),
        .addr(addr), .wr_data(wr_data),
        .ustimer0_val(ustimer0_val), .mstimer0_val(mstimer0_val),
        .mstimer1_val(mstimer1_val), .power_status(power_status),
        .ign_capture_val(ign_capture_val), .priority_val(priority_val),
        .load(load), .load_data(load_data), .rd_data(rd_data),
        .efi_len_us(efi_len_us), .ign_timeout_len(ign_timeout_len),
        .soft_event(soft_event)
    );

    // microsecond timer, then the two millisecond timers.
    countdown_timer u_ustimer0 (
        .sysclk(sysclk), .rst_n(rst_n), .load(load[REG_USTIMER0]), .load_data(load_data),
        .count_event(ticks.us_pulse), .count(ustimer0_val), .expired(ustimer0_expired)
    );
    countdown_timer u_mstimer0 (
        .sysclk(sysclk), .rst_n(rst_n), .load(load[REG_MSTIMER0]), .load_data(load_data),
        .count_event(ticks.ms_pulse), .count(mstimer0_val), .expired(mstimer0_expired)
    );
    countdown_timer u_mstimer1 (
        .sysclk(sysclk), .rst_n(rst_n), .load(load[REG_MSTIMER1]), .load_data(load_data),
        .count_event(ticks.ms_pulse), .count(mstimer1_val), .expired(mstimer1_expired)
    );

    power_relay #(.PWM_PERIOD_US(PWM_PERIOD_US)) u_power_relay (
        .sysclk(sysclk), .rst_n(rst_n), .ticks(ticks),
        .duty_load(load[REG_POWER_DUTY]), .load_data(load_data),
        .power_lost(power_lost), .ignition_switch_off(ignition_switch_off),
        .power_status(power_status), .power_lost_sync(power_lost_sync),
        .ign_switch_off_sync(ign_switch_off_sync), .power_relay_pwm(power_relay_pwm)
    );

    ignition_capture #(.BLANK_TICKS(BLANK_TICKS)) u_ignition_capture (
        .sysclk(sysclk), .rst_n(rst_n), .ticks(ticks), .ign_coil_lo(ign_coil_lo),
        .ign_capture_val(ign_capture_val), .capture(capture), .timeout(timeout)
    );

    injector_timer u_injector_timer (
        .sysclk(sysclk), .rst_n(rst_n), .ticks(ticks), .capture(capture),
        .efi_len_us(efi_len_us), .ign_timeout_len(ign_timeout_len),
        .injector_open(injector_open), .puff(puff)
    );

    // event inputs in event_idx_e order, index 0 tied low.
    assign event_vec = {soft_event[3:0], !ign_switch_off_sync, ign_switch_off_sync,
                        mstimer1_expired, mstimer0_expired, ustimer0_expired,
                        puff, timeout, capture, power_lost_sync, 1'b0};

    event_controller u_event_controller (
        .sysclk(sysclk), .rst_n(rst_n), .soft_reset(soft_event[SOFT_RESET_BIT]),
        .event_in(event_vec), .priority_load(load[REG_EVENT_PRIORITY]),
        .load_data(load_data), .priority_val(priority_val), .irq(irq)
    );

    // soft-event bits brought out for a scope probe.
    assign scope = soft_event[14:13];

endmodule

// File: source/event_controller.sv
`timescale 1ns/1ps

module event_controller import engine_io_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  soft_reset,
    input  logic [NUM_EVENTS-1:0] event_in,
    input  logic                  priority_load,
    input  word_t                 load_data,
    output word_t                 priority_val,
    output logic                  irq
);

    logic [NUM_EVENTS-1:0] event_last;
    logic [NUM_EVENTS-1:0] pending;
    logic [NUM_EVENTS-1:0] rise;
    logic [NUM_EVENTS-1:0] ack_mask;
    event_idx_e            ack_idx;

    // rising edges only, index 0 never becomes pending.
    always_comb begin
        rise          = event_in & ~event_last;
        rise[EV_NONE] = 1'b0;
    end

    // the written index acknowledges that one event.
    assign ack_idx  = event_idx_e'(load_data[3:0]);
    assign ack_mask = priority_load ? (NUM_EVENTS'(1) << ack_idx) : '0;

    // history starts high, so inputs already high at reset raise nothing.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            event_last <= '1;
            pending    <= '0;
        end else if (soft_reset) begin
            event_last <= '1;
            pending    <= '0;
        end else begin
            event_last <= event_in;
            // a new edge wins over an acknowledge in the same cycle.
            pending    <= (pending & ~ack_mask) | rise;
        end
    end

    // lowest pending index is the most urgent.
    always_comb begin
        priority_val = '0;
        for (int i = NUM_EVENTS - 1; i > 0; i--) begin
            if (pending[i]) priority_val = word_t'(i);
        end
    end

    assign irq = |pending;

endmodule

// File: source/injector_timer.sv
`timescale 1ns/1ps

module injector_timer import engine_io_pkg::*; (
    input  logic  sysclk,
    input  logic  rst_n,
    tick_if.sink  ticks,
    input  logic  capture,
    input  word_t efi_len_us,
    input  word_t ign_timeout_len,
    output logic  injector_open,
    output logic  puff
);

    word_t limp_cnt;
    word_t us_left;
    logic  limp_fire;
    logic  start;
    logic  last_us;

    // limp mode fires a puff when the engine gives no captures.
    // a zero length leaves limp mode off.
    assign limp_fire = (ign_timeout_len != '0) && (limp_cnt >= ign_timeout_len);
    assign start     = (capture || limp_fire) && (efi_len_us != '0);
    assign last_us   = injector_open && ticks.us_pulse && (us_left == word_t'(1));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            limp_cnt <= '0;
        end else if (capture || limp_fire) begin
            limp_cnt <= '0;
        end else if (ticks.tick_pulse) begin
            limp_cnt <= limp_cnt + word_t'(1);
        end
    end

    // a new start retriggers a puff that is still running.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            injector_open <= 1'b0;
            us_left       <= '0;
            puff          <= 1'b0;
        end else begin
            if (start) begin
                injector_open <= 1'b1;
                us_left       <= efi_len_us;
            end else if (injector_open && ticks.us_pulse) begin
                us_left <= us_left - word_t'(1);
                if (last_us) injector_open <= 1'b0;
            end
            // one-cycle strobe at the end of each puff.
            puff <= last_us && !start;
        end
    end

endmodule

// File: source/ignition_capture.sv
`timescale 1ns/1ps

module ignition_capture import engine_io_pkg::*; #(
    parameter int BLANK_TICKS = 80
) (
    input  logic  sysclk,
    input  logic  rst_n,
    tick_if.sink  ticks,
    input  logic  ign_coil_lo,
    output word_t ign_capture_val,
    output logic  capture,
    output logic  timeout
);

    logic  coil_meta;
    logic  coil_sync;
    logic  coil_last;
    logic  coil_edge;
    word_t tick_cnt;

    // coil input is active low, invert before synchronizing.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            coil_meta <= 1'b0;
            coil_sync <= 1'b0;
            coil_last <= 1'b0;
        end else begin
            coil_meta <= !ign_coil_lo;
            coil_sync <= coil_meta;
            coil_last <= coil_sync;
        end
    end

    assign coil_edge = coil_sync && !coil_last;
    // edges inside the blanking window are treated as ringing.
    assign capture   = coil_edge && (tick_cnt > word_t'(BLANK_TICKS));
    // top bit of the counter marks a stalled engine.
    assign timeout   = tick_cnt[15];

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (capture || timeout) begin
            tick_cnt <= '0;
        end else if (ticks.tick_pulse) begin
            tick_cnt <= tick_cnt + word_t'(1);
        end
    end

    // period in ticks, taken from the counter before it clears.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ign_capture_val <= '0;
        end else if (capture) begin
            ign_capture_val <= tick_cnt;
        end
    end

endmodule

// File: source/power_relay.sv
`timescale 1ns/1ps

module power_relay import engine_io_pkg::*; #(
    parameter int PWM_PERIOD_US = 50
) (
    input  logic  sysclk,
    input  logic  rst_n,
    tick_if.sink  ticks,
    input  logic  duty_load,
    input  word_t load_data,
    input  logic  power_lost,
    input  logic  ignition_switch_off,
    output word_t power_status,
    output logic  power_lost_sync,
    output logic  ign_switch_off_sync,
    output logic  power_relay_pwm
);

    logic [DUTY_W-1:0] duty;
    logic [DUTY_W-1:0] period_cnt;
    logic              power_lost_meta;
    logic              ign_off_meta;

    // period counter runs on the raw strobe, so halt does not drop the relay.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else if (ticks.us_pulse_raw) begin
            if (period_cnt == DUTY_W'(PWM_PERIOD_US - 1)) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + DUTY_W'(1);
            end
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            duty                <= '0;
            power_lost_meta     <= 1'b0;
            power_lost_sync     <= 1'b0;
            ign_off_meta        <= 1'b0;
            ign_switch_off_sync <= 1'b0;
        end else begin
            if (duty_load) duty <= load_data[DUTY_W-1:0];
            // two-flop synchronizers for the board inputs.
            power_lost_meta     <= power_lost;
            power_lost_sync     <= power_lost_meta;
            ign_off_meta        <= ignition_switch_off;
            ign_switch_off_sync <= ign_off_meta;
        end
    end

    // high while the count is below duty, so duty 0 keeps the relay off.
    assign power_relay_pwm = (period_cnt < duty);

    // duty field in the low bits, input states at bits 6 and 7.
    assign power_status = word_t'({ign_switch_off_sync, power_lost_sync, duty});

endmodule

// File: source/countdown_timer.sv
`timescale 1ns/1ps

module countdown_timer import engine_io_pkg::*; (
    input  logic  sysclk,
    input  logic  rst_n,
    input  logic  load,
    input  word_t load_data,
    input  logic  count_event,
    output word_t count,
    output logic  expired
);

    logic step;

    // decrement only while there is something left.
    assign step = count_event && (count != '0);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            expired <= 1'b0;
        end else begin
            // a load wins over a pending decrement.
            if (load) begin
                count <= load_data;
            end else if (step) begin
                count <= count - word_t'(1);
            end
            // pulse together with the count reaching zero.
            expired <= !load && step && (count == word_t'(1));
        end
    end

endmodule

// File: source/reg_map.sv
`timescale 1ns/1ps

module reg_map import engine_io_pkg::*; (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic                rd_en,
    input  reg_addr_e           addr,
    input  word_t               wr_data,
    input  word_t               ustimer0_val,
    input  word_t               mstimer0_val,
    input  word_t               mstimer1_val,
    input  word_t               power_status,
    input  word_t               ign_capture_val,
    input  word_t               priority_val,
    output logic [NUM_REGS-1:0] load,
    output word_t               load_data,
    output word_t               rd_data,
    output word_t               efi_len_us,
    output word_t               ign_timeout_len,
    output word_t               soft_event
);

    word_t rd_sel;

    // one strobe per register, the capture register cannot be written.
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            load[i] = wr_en && (addr == reg_addr_e'(i)) && (i != int'(REG_IGN_CAPTURE));
        end
    end

    // peripherals take the bus word on the same edge as their strobe.
    assign load_data = wr_data;

    // plain data registers owned here.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            efi_len_us      <= '0;
            ign_timeout_len <= '0;
            soft_event      <= '0;
        end else begin
            if (load[REG_EFI_LEN_US]) efi_len_us <= wr_data;
            if (load[REG_IGN_TIMEOUT]) ign_timeout_len <= wr_data;
            if (load[REG_SOFT_EVENT]) soft_event <= wr_data;
        end
    end

    // read mux.
    always_comb begin
        case (addr)
            REG_USTIMER0:       rd_sel = ustimer0_val;
            REG_MSTIMER0:       rd_sel = mstimer0_val;
            REG_MSTIMER1:       rd_sel = mstimer1_val;
            REG_POWER_DUTY:     rd_sel = power_status;
            REG_IGN_CAPTURE:    rd_sel = ign_capture_val;
            REG_EFI_LEN_US:     rd_sel = efi_len_us;
            REG_IGN_TIMEOUT:    rd_sel = ign_timeout_len;
            REG_SOFT_EVENT:     rd_sel = soft_event;
            REG_EVENT_PRIORITY: rd_sel = priority_val;
            default:            rd_sel = '0;
        endcase
    end

    // read data is valid the cycle after rd_en and holds until the next read.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rd_sel;
        end
    end

endmodule

// File: source/timebase.sv
`timescale 1ns/1ps

module timebase #(
    parameter int CLK_PER_US   = 50,
    parameter int US_PER_TICK  = 20,
    parameter int TICKS_PER_MS = 50
) (
    input  logic sysclk,
    input  logic rst_n,
    input  logic halt,
    tick_if.src  ticks
);

    localparam int DIV_W  = $clog2(CLK_PER_US + 1);
    localparam int US_W   = $clog2(US_PER_TICK + 1);
    localparam int TICK_W = $clog2(TICKS_PER_MS + 1);

    logic [DIV_W-1:0]  div_cnt;
    logic [US_W-1:0]   us_cnt;
    logic [TICK_W-1:0] tick_cnt;

    // cycle divider wraps on its own, independent of halt.
    assign ticks.us_pulse_raw = (div_cnt == DIV_W'(CLK_PER_US - 1));
    // halt only masks the strobe.
    assign ticks.us_pulse     = ticks.us_pulse_raw && !halt;
    assign ticks.tick_pulse   = ticks.us_pulse && (us_cnt == US_W'(US_PER_TICK - 1));
    assign ticks.ms_pulse     = ticks.tick_pulse && (tick_cnt == TICK_W'(TICKS_PER_MS - 1));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            us_cnt   <= '0;
            tick_cnt <= '0;
        end else begin
            div_cnt <= ticks.us_pulse_raw ? '0 : div_cnt + DIV_W'(1);
            // microseconds within the current tick.
            if (ticks.tick_pulse) begin
                us_cnt <= '0;
            end else if (ticks.us_pulse) begin
                us_cnt <= us_cnt + US_W'(1);
            end
            // ticks within the current millisecond.
            if (ticks.ms_pulse) begin
                tick_cnt <= '0;
            end else if (ticks.tick_pulse) begin
                tick_cnt <= tick_cnt + TICK_W'(1);
            end
        end
    end

endmodule

// File: source/tick_if.sv
`timescale 1ns/1ps

interface tick_if;

    // microsecond strobe that keeps running through halt.
    logic us_pulse_raw;
    // microsecond strobe, stopped while halted.
    logic us_pulse;
    // one strobe per ignition tick of gated microseconds.
    logic tick_pulse;
    // one strobe per millisecond of ticks.
    logic ms_pulse;

    modport src (output us_pulse_raw, us_pulse, tick_pulse, ms_pulse);
    modport sink (input us_pulse_raw, us_pulse, tick_pulse, ms_pulse);

endinterface

// File: source/engine_io_pkg.sv
package engine_io_pkg;

    // register data word on the bus.
    typedef logic [15:0] word_t;

    // bus register addresses.
    typedef enum logic [3:0] {
        REG_USTIMER0       = 4'd0,
        REG_MSTIMER0       = 4'd1,
        REG_MSTIMER1       = 4'd2,
        REG_POWER_DUTY     = 4'd3,
        // read only, holds the last captured coil period.
        REG_IGN_CAPTURE    = 4'd4,
        REG_EFI_LEN_US     = 4'd5,
        REG_IGN_TIMEOUT    = 4'd6,
        REG_SOFT_EVENT     = 4'd7,
        REG_EVENT_PRIORITY = 4'd8
    } reg_addr_e;

    // number of decoded registers, sizes the load strobe vector.
    localparam int NUM_REGS = int'(REG_EVENT_PRIORITY) + 1;

    // event indices, a lower index is more urgent.
    typedef enum logic [3:0] {
        EV_NONE           = 4'd0,
        EV_POWER_LOST     = 4'd1,
        EV_IGN_CAPTURE    = 4'd2,
        EV_IGN_TIMEOUT    = 4'd3,
        EV_PUFF_END       = 4'd4,
        EV_USTIMER0       = 4'd5,
        EV_MSTIMER0       = 4'd6,
        EV_MSTIMER1       = 4'd7,
        EV_IGN_SWITCH_OFF = 4'd8,
        EV_IGN_SWITCH_ON  = 4'd9,
        EV_SOFT0          = 4'd10,
        EV_SOFT1          = 4'd11,
        EV_SOFT2          = 4'd12,
        EV_SOFT3          = 4'd13
    } event_idx_e;

    localparam int NUM_EVENTS = 14;
    // relay PWM duty field width.
    localparam int DUTY_W = 6;
    // soft-event bit that holds the event controller in reset.
    localparam int SOFT_RESET_BIT = 15;

endpackage
